//--- all.f
logic/RingBusPkg.sv
logic/MmioTimeout.sv
logic/MmioBusFsm.sv
logic/RingNodeSram.sv
logic/RingNodeRom.sv
logic/RingNodeMmio.sv
logic/RingMemL2.sv
sim/RingMemL2_props.sv
sim/RingMemL2Tb.sv

//--- logic/MmioBusFsm.sv
`timescale 1ns/100ps
`default_nettype none

module MmioBusFsm
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,
	input wire start,
	input wire MmioOk busOk,
	input wire slotIdle,
	input wire expired,
	output logic busActive,
	output logic captureData,
	output logic faulted,
	output logic insert,
	output logic timerRun
);

	MmioState state;
	MmioState nextState;
	logic devDone;	// device gave a final answer

	assign devDone = (busOk == OK_OK) || (busOk == OK_FAULT);

	always_comb
	begin
		nextState = state;
		case (state)
			MMIO_IDLE:    if (start) nextState = MMIO_BUS;
			MMIO_BUS:     if (devDone || expired) nextState = MMIO_RESP;
			MMIO_RESP:    if (slotIdle) nextState = MMIO_RELEASE;
			MMIO_RELEASE: if (busOk == OK_READY) nextState = MMIO_IDLE;
			default:      nextState = MMIO_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			state <= MMIO_IDLE;
		else
			state <= nextState;
	end

	// sticky until the next transaction starts
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			faulted <= 1'b0;
		else if ((state == MMIO_IDLE) && start)
			faulted <= 1'b0;
		else if ((state == MMIO_BUS) && (busOk != OK_OK) && ((busOk == OK_FAULT) || expired))
			faulted <= 1'b1;	// an OK in the expiry cycle still wins
	end

	assign busActive   = (state == MMIO_BUS);
	assign timerRun    = (state == MMIO_BUS) && !devDone;
	assign captureData = (state == MMIO_BUS) && (busOk == OK_OK);
	assign insert      = (state == MMIO_RESP) && slotIdle;

endmodule

`default_nettype wire

//--- logic/MmioTimeout.sv
`timescale 1ns/100ps
`default_nettype none

module MmioTimeout
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,
	input wire run,
	output logic expired
);

	logic [MMIO_TIMER_W-1:0] count;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			count <= '0;
		else if (!run)
			count <= '0;	// restart for every transaction
		else if (count != MMIO_TIMER_W'(MMIO_TIMEOUT))
			count <= count + 1'b1;	// saturates at the limit
	end

	assign expired = run && (count == MMIO_TIMER_W'(MMIO_TIMEOUT));

endmodule

`default_nettype wire

//--- logic/RingBusPkg.sv
`default_nettype none

package RingBusPkg;

	localparam int SEQ_W  = 16;
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int WORD_SHIFT = 3;	// 8-byte words

	// ring slot opcodes, zero marks an empty slot
	typedef enum logic [7:0] {
		OPM_IDLE  = 8'h00,
		OPM_LDX   = 8'h10,
		OPM_STX   = 8'h20,
		OPM_OKLD  = 8'h50,
		OPM_OKST  = 8'h60,
		OPM_FAULT = 8'h7F
	} RingOpm;

	typedef enum logic [1:0] {
		OK_READY = 2'b00,	// device idle, can take a new request
		OK_OK    = 2'b01,
		OK_HOLD  = 2'b10,	// still busy
		OK_FAULT = 2'b11
	} MmioOk;

	typedef enum logic [1:0] {
		MMIO_IDLE,
		MMIO_BUS,
		MMIO_RESP,
		MMIO_RELEASE
	} MmioState;

	localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0001_0000;
	localparam int SRAM_WORDS = 512;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

	localparam logic [ADDR_W-1:0] ROM_BASE = 32'h0000_0000;
	localparam int ROM_WORDS = 512;
	localparam int ROM_IDX_W = $clog2(ROM_WORDS);
	localparam logic [DATA_W-1:0] ROM_SEED   = 64'h0000_0000_0000_00A5;
	localparam logic [DATA_W-1:0] ROM_SPREAD = 64'h0101_0101_0101_0101;

	localparam logic [3:0] MMIO_TOP = 4'hF;	// top nibble of MMIO space
	localparam int MMIO_TIMEOUT = 64;
	localparam int MMIO_TIMER_W = $clog2(MMIO_TIMEOUT + 1);

	function automatic logic isReq(input RingOpm opm);
		return (opm == OPM_LDX) || (opm == OPM_STX);
	endfunction

	// windows compared on offset so a wrapped address falls outside
	function automatic logic inSram(input logic [ADDR_W-1:0] addr);
		return (addr - SRAM_BASE) < ADDR_W'(SRAM_WORDS << WORD_SHIFT);
	endfunction

	function automatic logic inRom(input logic [ADDR_W-1:0] addr);
		return (addr - ROM_BASE) < ADDR_W'(ROM_WORDS << WORD_SHIFT);
	endfunction

	function automatic logic inMmio(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1 -: 4] == MMIO_TOP;
	endfunction

	// ROM contents, seed xor word index spread over every byte
	function automatic logic [DATA_W-1:0] romWord(input int unsigned n);
		return (ROM_SEED ^ DATA_W'(n)) * ROM_SPREAD;
	endfunction

endpackage

`default_nettype wire

//--- logic/RingMemL2.sv
`timescale 1ns/100ps
`default_nettype none

module RingMemL2
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,

	input wire [SEQ_W-1:0] seqIn,
	input wire RingOpm opmIn,
	input wire [ADDR_W-1:0] addrIn,
	input wire [DATA_W-1:0] dataIn,

	output wire [SEQ_W-1:0] seqOut,
	output wire RingOpm opmOut,
	output wire [ADDR_W-1:0] addrOut,
	output wire [DATA_W-1:0] dataOut,

	output wire [ADDR_W-1:0] mmioAddr,
	output wire RingOpm mmioOpm,
	output wire [DATA_W-1:0] mmioOutData,
	input wire [DATA_W-1:0] mmioInData,
	input wire MmioOk mmioOk
);

	// sram -> rom stage
	wire [SEQ_W-1:0] s2rSeq;
	wire RingOpm s2rOpm;
	wire [ADDR_W-1:0] s2rAddr;
	wire [DATA_W-1:0] s2rData;

	// rom -> mmio stage
	wire [SEQ_W-1:0] r2mSeq;
	wire RingOpm r2mOpm;
	wire [ADDR_W-1:0] r2mAddr;
	wire [DATA_W-1:0] r2mData;

	RingNodeSram sramNode (
		.clock   (clock),
		.arstN   (arstN),
		.seqIn   (seqIn),
		.opmIn   (opmIn),
		.addrIn  (addrIn),
		.dataIn  (dataIn),
		.seqOut  (s2rSeq),
		.opmOut  (s2rOpm),
		.addrOut (s2rAddr),
		.dataOut (s2rData)
	);

	RingNodeRom romNode (
		.clock   (clock),
		.arstN   (arstN),
		.seqIn   (s2rSeq),
		.opmIn   (s2rOpm),
		.addrIn  (s2rAddr),
		.dataIn  (s2rData),
		.seqOut  (r2mSeq),
		.opmOut  (r2mOpm),
		.addrOut (r2mAddr),
		.dataOut (r2mData)
	);

	// last stage, also bridges out to the register bus
	RingNodeMmio mmioNode (
		.clock       (clock),
		.arstN       (arstN),
		.seqIn       (r2mSeq),
		.opmIn       (r2mOpm),
		.addrIn      (r2mAddr),
		.dataIn      (r2mData),
		.seqOut      (seqOut),
		.opmOut      (opmOut),
		.addrOut     (addrOut),
		.dataOut     (dataOut),
		.mmioAddr    (mmioAddr),
		.mmioOpm     (mmioOpm),
		.mmioOutData (mmioOutData),
		.mmioInData  (mmioInData),
		.mmioOk      (mmioOk)
	);

endmodule

`default_nettype wire

//--- logic/RingNodeMmio.sv
`timescale 1ns/100ps
`default_nettype none

module RingNodeMmio
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,

	input wire [SEQ_W-1:0] seqIn,
	input wire RingOpm opmIn,
	input wire [ADDR_W-1:0] addrIn,
	input wire [DATA_W-1:0] dataIn,

	output logic [SEQ_W-1:0] seqOut,
	output RingOpm opmOut,
	output logic [ADDR_W-1:0] addrOut,
	output logic [DATA_W-1:0] dataOut,

	output logic [ADDR_W-1:0] mmioAddr,
	output RingOpm mmioOpm,
	output logic [DATA_W-1:0] mmioOutData,
	input wire [DATA_W-1:0] mmioInData,
	input wire MmioOk mmioOk
);

	logic busy;	// request held, FSM out of idle
	logic respSent;	// response on the ring, bus still releasing
	logic start;
	logic slotIdle;
	logic expired;
	logic busActive;
	logic captureData;
	logic faulted;
	logic insert;
	logic timerRun;

	logic [SEQ_W-1:0] capSeq;
	RingOpm capOpm;
	logic [ADDR_W-1:0] capAddr;
	logic [DATA_W-1:0] capData;
	RingOpm respOpm;

	assign start    = !busy && isReq(opmIn) && inMmio(addrIn);
	assign slotIdle = (opmIn == OPM_IDLE);

	MmioBusFsm busFsm (
		.clock       (clock),
		.arstN       (arstN),
		.start       (start),
		.busOk       (mmioOk),
		.slotIdle    (slotIdle),
		.expired     (expired),
		.busActive   (busActive),
		.captureData (captureData),
		.faulted     (faulted),
		.insert      (insert),
		.timerRun    (timerRun)
	);

	MmioTimeout busTimer (
		.clock   (clock),
		.arstN   (arstN),
		.run     (timerRun),
		.expired (expired)
	);

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			capSeq  <= seqIn;
			capOpm  <= opmIn;
			capAddr <= addrIn;
			capData <= dataIn;
		end
		else if (captureData && (capOpm == OPM_LDX))
			capData <= mmioInData;	// load result replaces request data
	end

	// tracks the FSM: idle again once the device reports ready after insert
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			busy     <= 1'b0;
			respSent <= 1'b0;
		end
		else if (start)
			busy <= 1'b1;
		else if (insert)
			respSent <= 1'b1;
		else if (respSent && (mmioOk == OK_READY))
		begin
			busy     <= 1'b0;
			respSent <= 1'b0;
		end
	end

	always_comb
	begin
		if (faulted)
			respOpm = OPM_FAULT;
		else if (capOpm == OPM_LDX)
			respOpm = OPM_OKLD;
		else
			respOpm = OPM_OKST;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			seqOut  <= '0;
			opmOut  <= OPM_IDLE;
			addrOut <= '0;
			dataOut <= '0;
		end
		else if (start)
		begin
			seqOut  <= '0;	// request leaves the ring, slot freed
			opmOut  <= OPM_IDLE;
			addrOut <= '0;
			dataOut <= '0;
		end
		else if (insert)
		begin
			seqOut  <= capSeq;
			opmOut  <= respOpm;
			addrOut <= capAddr;
			dataOut <= capData;
		end
		else
		begin
			seqOut  <= seqIn;
			opmOut  <= opmIn;
			addrOut <= addrIn;
			dataOut <= dataIn;
		end
	end

	assign mmioAddr    = capAddr;
	assign mmioOutData = capData;
	assign mmioOpm     = busActive ? capOpm : OPM_IDLE;

endmodule

`default_nettype wire

//--- logic/RingNodeRom.sv
`timescale 1ns/100ps
`default_nettype none

module RingNodeRom
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,

	input wire [SEQ_W-1:0] seqIn,
	input wire RingOpm opmIn,
	input wire [ADDR_W-1:0] addrIn,
	input wire [DATA_W-1:0] dataIn,

	output logic [SEQ_W-1:0] seqOut,
	output RingOpm opmOut,
	output logic [ADDR_W-1:0] addrOut,
	output logic [DATA_W-1:0] dataOut
);

	logic [DATA_W-1:0] romTable [ROM_WORDS];
	logic [ADDR_W-1:0] offset;
	logic [ROM_IDX_W-1:0] wordIdx;
	logic hit;

	// constant table, fixed at elaboration
	for (genvar n = 0; n < ROM_WORDS; n++)
	begin : genTable
		assign romTable[n] = romWord(n);
	end

	assign offset  = addrIn - ROM_BASE;
	assign wordIdx = offset[WORD_SHIFT +: ROM_IDX_W];
	assign hit     = isReq(opmIn) && inRom(addrIn);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			seqOut  <= '0;
			opmOut  <= OPM_IDLE;
			addrOut <= '0;
			dataOut <= '0;
		end
		else
		begin
			seqOut  <= seqIn;
			addrOut <= addrIn;
			opmOut  <= opmIn;
			dataOut <= dataIn;

			if (hit)
			begin
				if (opmIn == OPM_LDX)
				begin
					opmOut  <= OPM_OKLD;
					dataOut <= romTable[wordIdx];
				end
				else
					opmOut <= OPM_FAULT;	// read-only window
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/RingNodeSram.sv
`timescale 1ns/100ps
`default_nettype none

module RingNodeSram
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,

	input wire [SEQ_W-1:0] seqIn,
	input wire RingOpm opmIn,
	input wire [ADDR_W-1:0] addrIn,
	input wire [DATA_W-1:0] dataIn,

	output logic [SEQ_W-1:0] seqOut,
	output RingOpm opmOut,
	output logic [ADDR_W-1:0] addrOut,
	output logic [DATA_W-1:0] dataOut
);

	logic [DATA_W-1:0] mem [SRAM_WORDS];
	logic [ADDR_W-1:0] offset;
	logic [SRAM_IDX_W-1:0] wordIdx;
	logic hit;	// request for this window

	assign offset  = addrIn - SRAM_BASE;
	assign wordIdx = offset[WORD_SHIFT +: SRAM_IDX_W];
	assign hit     = isReq(opmIn) && inSram(addrIn);

	// store port
	always_ff @(posedge clock)
	begin
		if (hit && (opmIn == OPM_STX))
			mem[wordIdx] <= dataIn;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			seqOut  <= '0;
			opmOut  <= OPM_IDLE;
			addrOut <= '0;
			dataOut <= '0;
		end
		else
		begin
			seqOut  <= seqIn;
			addrOut <= addrIn;
			opmOut  <= opmIn;
			dataOut <= dataIn;

			if (hit)
			begin
				if (opmIn == OPM_LDX)
				begin
					opmOut  <= OPM_OKLD;
					dataOut <= mem[wordIdx];	// old contents on a same-cycle store
				end
				else
				begin
					opmOut <= OPM_OKST;	// data word echoes what was stored
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/RingMemL2Tb.sv
`timescale 1ns/100ps
`default_nettype none

module RingMemL2Tb
	import RingBusPkg::*;
();

	localparam logic [ADDR_W-1:0] DEAD_ADDR = 32'hF000_0F00;	// device never answers here

	logic clock;
	logic arstN;
	logic [SEQ_W-1:0] seqIn;
	RingOpm opmIn;
	logic [ADDR_W-1:0] addrIn;
	logic [DATA_W-1:0] dataIn;
	wire [SEQ_W-1:0] seqOut;
	RingOpm opmOut;
	wire [ADDR_W-1:0] addrOut;
	wire [DATA_W-1:0] dataOut;
	wire [ADDR_W-1:0] mmioAddr;
	RingOpm mmioOpm;
	wire [DATA_W-1:0] mmioOutData;
	logic [DATA_W-1:0] mmioInData;
	MmioOk mmioOk;

	// expected responses, indexed by seq
	bit expValid [256];
	RingOpm expOpm [256];
	logic [ADDR_W-1:0] expAddr [256];
	logic [DATA_W-1:0] expData [256];
	int expLat [256];	// 0 when the latency varies
	int issueCyc [256];
	logic [DATA_W-1:0] stored [16];

	integer seed = 40258;
	int cycleCount = 0;
	int pending = 0;
	int checkErrors = 0;
	int timeoutErrors = 0;
	int propErrors;
	string testName = "reset";
	bit devActive = 0;
	int holdLeft;

	// transaction the register bus should carry next
	int busSeq = 0;
	RingOpm busOpm = OPM_IDLE;
	logic [ADDR_W-1:0] busAddr = '0;
	logic [DATA_W-1:0] busData = '0;

	RingMemL2 RingMemL2_inst (
		.clock       (clock),
		.arstN       (arstN),
		.seqIn       (seqIn),
		.opmIn       (opmIn),
		.addrIn      (addrIn),
		.dataIn      (dataIn),
		.seqOut      (seqOut),
		.opmOut      (opmOut),
		.addrOut     (addrOut),
		.dataOut     (dataOut),
		.mmioAddr    (mmioAddr),
		.mmioOpm     (mmioOpm),
		.mmioOutData (mmioOutData),
		.mmioInData  (mmioInData),
		.mmioOk      (mmioOk)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock)
		cycleCount++;

	// register device: random hold, then OK, ready once the bridge lets go
	always @(posedge clock)
	begin
		#1;
		if (mmioOpm == OPM_IDLE)
		begin
			mmioOk = OK_READY;
			devActive = 0;
		end
		else if (!devActive)
		begin
			devActive = 1;
			checkEq("bus opm", busSeq, busOpm, mmioOpm);
			checkEq("bus addr", busSeq, busAddr, mmioAddr);
			if (busOpm == OPM_STX)
				checkEq("bus data", busSeq, busData, mmioOutData);
			holdLeft = 1 + ($unsigned($random(seed)) % 20);
			mmioOk = OK_HOLD;
		end
		else if ((mmioAddr == DEAD_ADDR) || (holdLeft > 1))
		begin
			holdLeft--;
			mmioOk = OK_HOLD;
		end
		else
		begin
			mmioOk = OK_OK;
			mmioInData = 64'(mmioAddr) * 3;
		end
	end

	function automatic logic [DATA_W-1:0] romRef(input int idx);
		return (ROM_SEED ^ 64'(idx)) * 64'h0101_0101_0101_0101;
	endfunction

	task automatic checkEq(input string field, input int s, input logic [63:0] expV,
		input logic [63:0] actV);
		assert (actV === expV)
		else
		begin
			checkErrors++;
			$display("FAIL %s seq %0d %s expected %h actual %h", testName, s, field, expV, actV);
		end
	endtask

	task automatic checkResponse();
		int s;
		s = int'(seqOut[7:0]);
		assert ((seqOut < 256) && expValid[s])
		else
		begin
			checkErrors++;
			$display("response with seq %0d arrived but no such request is pending", seqOut);
		end
		if ((seqOut < 256) && expValid[s])
		begin
			checkEq("opm", s, expOpm[s], opmOut);
			checkEq("addr", s, expAddr[s], addrOut);
			checkEq("data", s, expData[s], dataOut);
			if (expLat[s] != 0)
				checkEq("latency", s, expLat[s], cycleCount - issueCyc[s]);
			expValid[s] = 0;
			pending--;
		end
	endtask

	always @(negedge clock)
	begin
		if (arstN && (opmOut != OPM_IDLE))
			checkResponse();
	end

	// request the bridge should put on the register bus
	task automatic expectBus(input int s, input RingOpm opm, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		busSeq = s;
		busOpm = opm;
		busAddr = addr;
		busData = data;
	endtask

	// drives one slot for one cycle, called just after a rising edge
	task automatic sendReq(input int s, input RingOpm opm, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input RingOpm eOpm, input logic [DATA_W-1:0] eData,
		input int lat);
		expValid[s] = 1;
		expOpm[s] = eOpm;
		expAddr[s] = addr;
		expData[s] = eData;
		expLat[s] = lat;
		issueCyc[s] = cycleCount;
		pending++;
		seqIn = SEQ_W'(s);
		opmIn = opm;
		addrIn = addr;
		dataIn = data;
		@(posedge clock);
		#1;
	endtask

	task automatic idleCycles(input int n);
		opmIn = OPM_IDLE;
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic waitPending(input int limit);
		int n;
		n = 0;
		opmIn = OPM_IDLE;
		while ((pending != 0) && (n < limit))
		begin
			@(posedge clock);
			#1;
			n++;
		end
		if (pending != 0)
		begin
			timeoutErrors++;
			$display("timeout in %s, %0d responses never came back", testName, pending);
			foreach (expValid[i])
				expValid[i] = 0;
			pending = 0;
		end
	endtask

	initial
	begin
		arstN = 1'b0;
		seqIn = '0;
		opmIn = OPM_IDLE;
		addrIn = '0;
		dataIn = '0;
		mmioInData = '0;
		mmioOk = OK_READY;
		repeat (16) @(posedge clock);
		#1 arstN = 1'b1;
		idleCycles(2);

		testName = "sram";
		for (int i = 0; i < 16; i++)
		begin
			stored[i] = {$random(seed), $random(seed)};
			sendReq(i, OPM_STX, SRAM_BASE + i * 8 * 31, stored[i], OPM_OKST, stored[i], 3);
		end
		for (int i = 0; i < 16; i++)
			sendReq(16 + i, OPM_LDX, SRAM_BASE + i * 8 * 31, '0, OPM_OKLD, stored[i], 3);
		waitPending(20);

		testName = "rom";
		sendReq(32, OPM_LDX, ROM_BASE, '0, OPM_OKLD, romRef(0), 3);
		sendReq(33, OPM_LDX, ROM_BASE + 8, '0, OPM_OKLD, romRef(1), 3);
		sendReq(34, OPM_LDX, ROM_BASE + 37 * 8, '0, OPM_OKLD, romRef(37), 3);
		sendReq(35, OPM_LDX, ROM_BASE + 511 * 8, '0, OPM_OKLD, romRef(511), 3);
		sendReq(36, OPM_STX, ROM_BASE + 32'h100, 64'hBEEF, OPM_FAULT, 64'hBEEF, 3);
		waitPending(20);

		testName = "mmio";
		expectBus(40, OPM_LDX, 32'hF000_0010, '0);
		sendReq(40, OPM_LDX, 32'hF000_0010, '0, OPM_OKLD, 64'(32'hF000_0010) * 3, 0);
		waitPending(60);
		idleCycles(2);
		expectBus(41, OPM_STX, 32'hF000_0020, 64'h1234);
		sendReq(41, OPM_STX, 32'hF000_0020, 64'h1234, OPM_OKST, 64'h1234, 0);
		waitPending(60);
		idleCycles(2);

		testName = "mmio timeout";
		expectBus(50, OPM_LDX, DEAD_ADDR, 64'h55);
		sendReq(50, OPM_LDX, DEAD_ADDR, 64'h55, OPM_FAULT, 64'h55, 0);
		idleCycles(6);
		sendReq(51, OPM_LDX, 32'hF000_0100, 64'h66, OPM_LDX, 64'h66, 3);	// bridge busy
		waitPending(200);
		idleCycles(2);

		testName = "unmapped";
		sendReq(60, OPM_LDX, 32'h4000_0000, 64'h77, OPM_LDX, 64'h77, 3);
		waitPending(20);
		idleCycles(5);

		propErrors = RingMemL2_inst.propsInst.failCount;
		$display("errors: %0d value, %0d timeout, %0d assertion",
			checkErrors, timeoutErrors, propErrors);
		if ((checkErrors + timeoutErrors + propErrors) == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/RingMemL2_props.sv
`timescale 1ns/100ps
`default_nettype none

module RingMemL2Props
	import RingBusPkg::*;
(
	input wire clock,
	input wire arstN,
	input wire [SEQ_W-1:0] seqIn,
	input wire RingOpm opmIn,
	input wire [ADDR_W-1:0] addrIn,
	input wire [SEQ_W-1:0] seqOut,
	input wire RingOpm opmOut,
	input wire [ADDR_W-1:0] addrOut,
	input wire RingOpm mmioOpm,
	input wire MmioOk mmioOk,
	input wire timerExpired,
	input wire [SEQ_W-1:0] slotSeq,
	input wire RingOpm slotOpm
);

	int failCount = 0;	// summed into the closing count line
	logic sramReq;
	logic romReq;

	assign sramReq = ((opmIn == OPM_LDX) || (opmIn == OPM_STX))
		&& ((addrIn - SRAM_BASE) < ADDR_W'(SRAM_WORDS * 8));
	assign romReq = ((opmIn == OPM_LDX) || (opmIn == OPM_STX))
		&& ((addrIn - ROM_BASE) < ADDR_W'(ROM_WORDS * 8));

	// bridge may only drop the request once the timer gives up
	holdStable: assert property (@(posedge clock) disable iff (!arstN)
		((mmioOk == OK_HOLD) && !timerExpired) |=> $stable(mmioOpm))
	else
	begin
		$error("mmioOpm changed while the device held the bus");
		failCount++;
	end

	fixedLatency: assert property (@(posedge clock) disable iff (!arstN)
		(sramReq || romReq) |-> ##3 ((seqOut == $past(seqIn, 3))
		&& (addrOut == $past(addrIn, 3))
		&& (opmOut inside {OPM_OKLD, OPM_OKST, OPM_FAULT})))
	else
	begin
		$error("local response missing 3 cycles after its request");
		failCount++;
	end

	// a busy slot leaves the bridge as it came, or emptied by a capture
	insertIdle: assert property (@(posedge clock) disable iff (!arstN)
		(slotOpm != OPM_IDLE) |=> ((opmOut == OPM_IDLE)
		|| ((opmOut == $past(slotOpm)) && (seqOut == $past(slotSeq)))))
	else
	begin
		$error("response inserted over a busy slot");
		failCount++;
	end

	resetIdle: assert property (@(posedge clock)
		$rose(arstN) |-> (opmOut == OPM_IDLE))
	else
	begin
		$error("ring output not idle after reset");
		failCount++;
	end

endmodule

// mmio node internals reached through the top level
bind RingMemL2 RingMemL2Props propsInst (
	.clock        (clock),
	.arstN        (arstN),
	.seqIn        (seqIn),
	.opmIn        (opmIn),
	.addrIn       (addrIn),
	.seqOut       (seqOut),
	.opmOut       (opmOut),
	.addrOut      (addrOut),
	.mmioOpm      (mmioOpm),
	.mmioOk       (mmioOk),
	.timerExpired (mmioNode.expired),
	.slotSeq      (r2mSeq),
	.slotOpm      (r2mOpm)
);

`default_nettype wire
